// ==== verilog/mips_pkg.sv ====
// Shared ISA encodings and pipeline records; opcodes outside the listed set decode as NOP
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [5:0] {
    ADD   = 6'd0,
    SUB   = 6'd1,
    AND   = 6'd2,
    OR    = 6'd3,
    SLT   = 6'd4,
    MUL   = 6'd5,
    LW    = 6'd8,
    SW    = 6'd9,
    ADDI  = 6'd10,
    SUBI  = 6'd11,
    SLTI  = 6'd12,
    BNEQZ = 6'd13,
    BEQZ  = 6'd14,
    HLT   = 6'd63
  } opcode_t;

  typedef enum logic [2:0] {RR, RM, LOAD, STORE, BRANCH, HALT, NOP} inst_class_t;

  typedef enum logic [1:0] {SEL_IMEM, SEL_DMEM, SEL_REG} mem_sel_t;

  typedef enum logic [1:0] {IDLE, RUN, HALTED} run_state_t;

  // Load port payload
  typedef struct packed {
    mem_sel_t mem_sel;
    word_t    addr;
    word_t    data;
  } prog_word_t;

  typedef struct packed {
    mem_sel_t mem_sel;
    word_t    addr;
  } rd_req_t;

  typedef struct packed {
    logic  valid;
    word_t npc;
    word_t ir;
  } if_id_t;

  typedef struct packed {
    logic        valid;
    inst_class_t cls;
    opcode_t     op;
    word_t       npc;
    word_t       a;
    word_t       b;
    word_t       imm;
    reg_idx_t    dest;
  } id_ex_t;

  typedef struct packed {
    logic        valid;
    inst_class_t cls;
    word_t       alu_out;
    word_t       b;
    reg_idx_t    dest;
  } ex_mem_t;

  typedef struct packed {
    logic        valid;
    inst_class_t cls;
    word_t       result;
    reg_idx_t    dest;
  } mem_wb_t;

endpackage

`default_nettype wire

// ==== verilog/mips_ctrl.sv ====
// Loads and reads back only outside RUN; addresses wrap to the depth of the selected memory
`timescale 1ns/1ns
`default_nettype none

module mips_ctrl #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic                 clk_1,
  input  logic                 rst,
  input  logic                 prog_valid,
  output logic                 prog_ready,
  input  mips_pkg::prog_word_t prog_data,
  input  logic                 start,
  input  logic                 rd_valid,
  output logic                 rd_ready,
  input  mips_pkg::rd_req_t    rd_req,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output mips_pkg::word_t      rsp_data,
  output logic                 running,
  output logic                 halted,
  input  logic                 halt_seen,
  output logic                 flush,
  output logic                 imem_wr,
  output logic                 dmem_wr,
  output logic                 reg_wr,
  output mips_pkg::word_t      wr_addr,
  output mips_pkg::word_t      wr_data,
  output mips_pkg::mem_sel_t   dbg_sel,
  output mips_pkg::word_t      dbg_addr,
  input  mips_pkg::word_t      imem_dbg,
  input  mips_pkg::word_t      dmem_dbg,
  input  mips_pkg::word_t      reg_dbg
);
  import mips_pkg::*;

  run_state_t state;
  logic       prog_fire;
  logic       rd_fire;
  word_t      dbg_word;

  function automatic word_t wrap_addr(mem_sel_t sel, word_t addr);
    case (sel)
      SEL_IMEM: return addr & word_t'(IMEM_DEPTH - 1);
      SEL_DMEM: return addr & word_t'(DMEM_DEPTH - 1);
      default:  return addr & word_t'(31);
    endcase
  endfunction

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (start) state <= RUN;
        RUN:     if (halt_seen) state <= HALTED;
        HALTED:  if (start) state <= RUN;
        default: state <= IDLE;
      endcase
    end
  end

  assign running = (state == RUN);
  assign halted  = (state == HALTED);
  // PC reset and pipeline clear ride on the start edge
  assign flush   = start && (state != RUN);

  assign prog_ready = (state != RUN);
  assign prog_fire  = prog_valid && prog_ready;
  assign imem_wr    = prog_fire && (prog_data.mem_sel == SEL_IMEM);
  assign dmem_wr    = prog_fire && (prog_data.mem_sel == SEL_DMEM);
  assign reg_wr     = prog_fire && (prog_data.mem_sel == SEL_REG);
  assign wr_addr    = wrap_addr(prog_data.mem_sel, prog_data.addr);
  assign wr_data    = prog_data.data;

  // Debug reads are combinational, so the request addresses them directly
  assign rd_ready = (state != RUN) && !rsp_valid;
  assign rd_fire  = rd_valid && rd_ready;
  assign dbg_sel  = rd_req.mem_sel;
  assign dbg_addr = wrap_addr(rd_req.mem_sel, rd_req.addr);

  always_comb begin
    case (dbg_sel)
      SEL_IMEM: dbg_word = imem_dbg;
      SEL_DMEM: dbg_word = dmem_dbg;
      default:  dbg_word = reg_dbg;
    endcase
  end

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      rsp_valid <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_1) begin
    if (rd_fire) begin
      rsp_data <= dbg_word;
    end
  end

  prog_hold_a: assert property (@(posedge clk_1) disable iff (!rst)
    prog_valid && !prog_ready |=> $stable(prog_data))
    else $error("prog_data changed while waiting for prog_ready");

  no_wr_in_run_a: assert property (@(posedge clk_1) disable iff (!rst)
    state == RUN |-> !(imem_wr || dmem_wr || reg_wr))
    else $error("memory write strobe fired during RUN");

endmodule

`default_nettype wire

// ==== verilog/mips_fetch.sv ====
// PC counts in words; fetch address wraps modulo IMEM_DEPTH, which must be a power of two
`timescale 1ns/1ns
`default_nettype none

module mips_fetch #(
  parameter int IMEM_DEPTH = 256
) (
  input  logic             clk_1,
  input  logic             rst,
  input  logic             flush,
  input  logic             stall,
  input  logic             take,
  input  mips_pkg::word_t  target,
  input  logic             squash,
  input  logic             imem_wr,
  input  mips_pkg::word_t  wr_addr,
  input  mips_pkg::word_t  wr_data,
  input  mips_pkg::word_t  dbg_addr,
  output mips_pkg::word_t  imem_dbg,
  output mips_pkg::if_id_t if_id
);
  import mips_pkg::*;

  localparam int AW = $clog2(IMEM_DEPTH);

  word_t  imem [IMEM_DEPTH];
  word_t  pc;
  word_t  fetch_addr;
  if_id_t if_id_q;

  always_ff @(posedge clk_1) begin
    if (imem_wr) begin
      imem[wr_addr[AW-1:0]] <= wr_data;
    end
  end

  assign imem_dbg = imem[dbg_addr[AW-1:0]];

  // Redirect wins over the sequential PC
  assign fetch_addr = take ? target : pc;

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      pc      <= '0;
      if_id_q <= '0;
    end else if (flush) begin
      pc            <= '0;
      if_id_q.valid <= 1'b0;
    end else if (!stall) begin
      pc      <= fetch_addr + 32'd1;
      if_id_q <= '{valid: 1'b1, npc: fetch_addr + 32'd1, ir: imem[fetch_addr[AW-1:0]]};
    end
  end

  // Wrong-path word behind a taken branch
  assign if_id = '{valid: if_id_q.valid & ~squash, npc: if_id_q.npc, ir: if_id_q.ir};

endmodule

`default_nettype wire

// ==== verilog/mips_decode.sv ====
// No hazard detection; operands are read from the register file as it stands this cycle
`timescale 1ns/1ns
`default_nettype none

module mips_decode (
  input  logic               clk_1,
  input  logic               rst,
  input  logic               flush,
  input  logic               stall,
  input  logic               squash,
  input  mips_pkg::if_id_t   if_id,
  output mips_pkg::reg_idx_t rs,
  output mips_pkg::reg_idx_t rt,
  input  mips_pkg::word_t    rs_data,
  input  mips_pkg::word_t    rt_data,
  output mips_pkg::id_ex_t   id_ex
);
  import mips_pkg::*;

  opcode_t     op;
  inst_class_t cls;
  word_t       imm;
  reg_idx_t    dest;

  assign op  = opcode_t'(if_id.ir[31:26]);
  assign rs  = if_id.ir[25:21];
  assign rt  = if_id.ir[20:16];
  assign imm = {{16{if_id.ir[15]}}, if_id.ir[15:0]};

  always_comb begin
    case (op)
      ADD, SUB, AND, OR, SLT, MUL: cls = RR;
      ADDI, SUBI, SLTI:            cls = RM;
      LW:                          cls = LOAD;
      SW:                          cls = STORE;
      BEQZ, BNEQZ:                 cls = BRANCH;
      HLT:                         cls = HALT;
      default:                     cls = NOP;
    endcase
  end

  // RR writes rd, immediate forms and loads write rt
  assign dest = (cls == RR) ? if_id.ir[15:11] : if_id.ir[20:16];

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      id_ex <= '0;
    end else if (flush) begin
      id_ex.valid <= 1'b0;
    end else if (!stall) begin
      id_ex <= '{valid: if_id.valid & ~squash, cls: cls, op: op, npc: if_id.npc,
                 a: rs_data, b: rt_data, imm: imm, dest: dest};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mips_regfile.sv ====
// Register zero ignores writes; caller muxes pipeline and load-port writes onto one port
`timescale 1ns/1ns
`default_nettype none

module mips_regfile (
  input  logic               clk_1,
  input  logic               rst,
  input  mips_pkg::reg_idx_t rs,
  input  mips_pkg::reg_idx_t rt,
  output mips_pkg::word_t    rs_data,
  output mips_pkg::word_t    rt_data,
  input  logic               we,
  input  mips_pkg::reg_idx_t wa,
  input  mips_pkg::word_t    wd,
  input  mips_pkg::reg_idx_t dbg_addr,
  output mips_pkg::word_t    dbg_data
);
  import mips_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wa != '0)) begin
      regs[wa] <= wd;
    end
  end

  // Zero stays zero since it is never written
  assign rs_data  = regs[rs];
  assign rt_data  = regs[rt];
  assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

// ==== verilog/mips_execute.sv ====
// Branches resolve here with no prediction; SLT and SLTI compare as signed values
`timescale 1ns/1ns
`default_nettype none

module mips_execute (
  input  logic              clk_1,
  input  logic              rst,
  input  logic              flush,
  input  logic              stall,
  input  mips_pkg::id_ex_t  id_ex,
  output logic              take,
  output mips_pkg::word_t   target,
  output mips_pkg::ex_mem_t ex_mem
);
  import mips_pkg::*;

  word_t alu_out;
  logic  a_zero;
  logic  cond;

  always_comb begin
    case (id_ex.cls)
      RR: begin
        case (id_ex.op)
          ADD:     alu_out = id_ex.a + id_ex.b;
          SUB:     alu_out = id_ex.a - id_ex.b;
          AND:     alu_out = id_ex.a & id_ex.b;
          OR:      alu_out = id_ex.a | id_ex.b;
          SLT:     alu_out = {31'd0, $signed(id_ex.a) < $signed(id_ex.b)};
          MUL:     alu_out = id_ex.a * id_ex.b;
          default: alu_out = '0;
        endcase
      end
      RM: begin
        case (id_ex.op)
          ADDI:    alu_out = id_ex.a + id_ex.imm;
          SUBI:    alu_out = id_ex.a - id_ex.imm;
          SLTI:    alu_out = {31'd0, $signed(id_ex.a) < $signed(id_ex.imm)};
          default: alu_out = '0;
        endcase
      end
      // Word index, wrapped by the data memory
      LOAD, STORE: alu_out = id_ex.a + id_ex.imm;
      BRANCH:      alu_out = target;
      default:     alu_out = '0;
    endcase
  end

  assign a_zero = (id_ex.a == '0);
  assign cond   = (id_ex.op == BEQZ) ? a_zero : !a_zero;
  assign target = id_ex.npc + id_ex.imm;
  assign take   = !stall && id_ex.valid && (id_ex.cls == BRANCH) && cond;

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      ex_mem <= '0;
    end else if (flush) begin
      ex_mem.valid <= 1'b0;
    end else if (!stall) begin
      ex_mem <= '{valid: id_ex.valid, cls: id_ex.cls, alu_out: alu_out,
                  b: id_ex.b, dest: id_ex.dest};
    end
  end

  // The squash must leave a bubble in EX right behind a taken branch
  take_branch_a: assert property (@(posedge clk_1) disable iff (!rst)
    take |=> !id_ex.valid)
    else $error("taken branch not followed by a bubble in EX");

endmodule

`default_nettype wire

// ==== verilog/mips_mem_wb.sv ====
// Data memory answers in the same cycle; address wraps modulo DMEM_DEPTH, a power of two
`timescale 1ns/1ns
`default_nettype none

module mips_mem_wb #(
  parameter int DMEM_DEPTH = 256
) (
  input  logic               clk_1,
  input  logic               rst,
  input  logic               flush,
  input  logic               stall,
  input  mips_pkg::ex_mem_t  ex_mem,
  input  logic               dmem_wr,
  input  mips_pkg::word_t    wr_addr,
  input  mips_pkg::word_t    wr_data,
  input  mips_pkg::word_t    dbg_addr,
  output mips_pkg::word_t    dmem_dbg,
  output logic               we,
  output mips_pkg::reg_idx_t wa,
  output mips_pkg::word_t    wd,
  output logic               halt_seen
);
  import mips_pkg::*;

  localparam int AW = $clog2(DMEM_DEPTH);

  word_t   dmem [DMEM_DEPTH];
  mem_wb_t mem_wb;
  logic    st_en;
  word_t   load_data;

  // Anything behind a retiring HLT must not commit
  assign st_en     = !stall && !halt_seen && ex_mem.valid && (ex_mem.cls == STORE);
  assign load_data = dmem[ex_mem.alu_out[AW-1:0]];
  assign dmem_dbg  = dmem[dbg_addr[AW-1:0]];

  always_ff @(posedge clk_1) begin
    if (dmem_wr) begin
      dmem[wr_addr[AW-1:0]] <= wr_data;
    end else if (st_en) begin
      dmem[ex_mem.alu_out[AW-1:0]] <= ex_mem.b;
    end
  end

  always_ff @(posedge clk_1 or negedge rst) begin
    if (!rst) begin
      mem_wb <= '0;
    end else if (flush) begin
      mem_wb.valid <= 1'b0;
    end else if (!stall) begin
      mem_wb <= '{valid: ex_mem.valid & ~halt_seen, cls: ex_mem.cls,
                  result: (ex_mem.cls == LOAD) ? load_data : ex_mem.alu_out,
                  dest: ex_mem.dest};
    end
  end

  // Writeback
  assign we = mem_wb.valid &&
              ((mem_wb.cls == RR) || (mem_wb.cls == RM) || (mem_wb.cls == LOAD));
  assign wa = mem_wb.dest;
  assign wd = mem_wb.result;

  // Drops after one cycle since the HLT itself is not kept
  assign halt_seen = mem_wb.valid && (mem_wb.cls == HALT);

endmodule

`default_nettype wire

// ==== verilog/mips_core_top.sv ====
// Single clock; programs must space dependent instructions by three, no forwarding or interlock
`timescale 1ns/1ns
`default_nettype none

module mips_core_top #(
  parameter int IMEM_DEPTH = 256,
  parameter int DMEM_DEPTH = 256
) (
  input  logic                 clk_1,
  input  logic                 rst,
  input  logic                 prog_valid,
  output logic                 prog_ready,
  input  mips_pkg::prog_word_t prog_data,
  input  logic                 start,
  input  logic                 rd_valid,
  output logic                 rd_ready,
  input  mips_pkg::rd_req_t    rd_req,
  output logic                 rsp_valid,
  input  logic                 rsp_ready,
  output mips_pkg::word_t      rsp_data,
  output logic                 running,
  output logic                 halted
);
  import mips_pkg::*;

  logic     stall, flush, halt_seen, take;
  logic     imem_wr, dmem_wr, reg_wr;
  word_t    target, wr_addr, wr_data, dbg_addr;
  word_t    imem_dbg, dmem_dbg, reg_dbg;
  if_id_t   if_id;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  reg_idx_t rs, rt, wb_wa, rf_wa;
  word_t    rs_data, rt_data, wb_wd, rf_wd;
  logic     wb_we, rf_we;

  assign stall = ~running;

  // Load-port register writes only happen outside RUN
  assign rf_we = wb_we | reg_wr;
  assign rf_wa = reg_wr ? wr_addr[4:0] : wb_wa;
  assign rf_wd = reg_wr ? wr_data : wb_wd;

  mips_ctrl #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) ctrl_i (
    .clk_1(clk_1), .rst(rst),
    .prog_valid(prog_valid), .prog_ready(prog_ready), .prog_data(prog_data),
    .start(start),
    .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_req(rd_req),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_data(rsp_data),
    .running(running), .halted(halted), .halt_seen(halt_seen), .flush(flush),
    .imem_wr(imem_wr), .dmem_wr(dmem_wr), .reg_wr(reg_wr),
    .wr_addr(wr_addr), .wr_data(wr_data),
    .dbg_sel(), .dbg_addr(dbg_addr),
    .imem_dbg(imem_dbg), .dmem_dbg(dmem_dbg), .reg_dbg(reg_dbg)
  );

  mips_fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
    .clk_1(clk_1), .rst(rst), .flush(flush), .stall(stall),
    .take(take), .target(target), .squash(take),
    .imem_wr(imem_wr), .wr_addr(wr_addr), .wr_data(wr_data),
    .dbg_addr(dbg_addr), .imem_dbg(imem_dbg), .if_id(if_id)
  );

  mips_decode decode_i (
    .clk_1(clk_1), .rst(rst), .flush(flush), .stall(stall), .squash(take),
    .if_id(if_id), .rs(rs), .rt(rt), .rs_data(rs_data), .rt_data(rt_data),
    .id_ex(id_ex)
  );

  mips_regfile regfile_i (
    .clk_1(clk_1), .rst(rst), .rs(rs), .rt(rt), .rs_data(rs_data), .rt_data(rt_data),
    .we(rf_we), .wa(rf_wa), .wd(rf_wd), .dbg_addr(dbg_addr[4:0]), .dbg_data(reg_dbg)
  );

  mips_execute execute_i (
    .clk_1(clk_1), .rst(rst), .flush(flush), .stall(stall),
    .id_ex(id_ex), .take(take), .target(target), .ex_mem(ex_mem)
  );

  mips_mem_wb #(.DMEM_DEPTH(DMEM_DEPTH)) mem_wb_i (
    .clk_1(clk_1), .rst(rst), .flush(flush), .stall(stall), .ex_mem(ex_mem),
    .dmem_wr(dmem_wr), .wr_addr(wr_addr), .wr_data(wr_data),
    .dbg_addr(dbg_addr), .dmem_dbg(dmem_dbg),
    .we(wb_we), .wa(wb_wa), .wd(wb_wd), .halt_seen(halt_seen)
  );

endmodule

`default_nettype wire

// ==== sim/tb_mips_cases.svh ====
// Rows share core state in order; register values written by earlier rows feed later ones
localparam int NUM_ROWS  = 5;
localparam int DATA_USED = 16;

// Per row: program, initial data words, random rsp_ready stalls, number of starts
task automatic build_row(input int row);
  prog_q.delete();
  data_q.delete();
  bp   = 1'b0;
  runs = 1;
  case (row)
    0: begin
      data_q.push_back(32'h1234_5678);
      data_q.push_back(32'hfedc_ba98);
      data_q.push_back(32'h0000_1003);
      data_q.push_back(32'h7fff_ffff);
      put_imm(LW, 0, 1, 0);
      put_imm(LW, 0, 2, 1);
      put_imm(LW, 0, 3, 2);
      put_imm(LW, 0, 4, 3);
      put_nops();
      put_rr(ADD, 1, 2, 5);
      put_rr(SUB, 1, 2, 6);
      put_rr(AND, 1, 2, 7);
      put_rr(OR, 1, 2, 8);
      put_rr(SLT, 2, 1, 9);
      put_rr(SLT, 1, 2, 10);
      put_rr(MUL, 1, 3, 11);
      put_rr(MUL, 4, 4, 12);
      // Destination zero must stay zero
      put_rr(ADD, 1, 2, 0);
      put_imm(HLT, 0, 0, 0);
    end
    1: begin
      put_imm(ADDI, 0, 13, -5);
      put_imm(ADDI, 0, 14, 100);
      put_nops();
      put_imm(SUBI, 14, 15, -20);
      put_imm(SLTI, 13, 16, -4);
      put_imm(SLTI, 14, 17, -1);
      put_imm(ADDI, 14, 18, -200);
      put_imm(HLT, 0, 0, 0);
    end
    2: begin
      bp = 1'b1;
      data_q.push_back(32'h8000_0001);
      data_q.push_back(32'h0bad_f00d);
      put_imm(ADDI, 0, 19, 10);
      put_imm(ADDI, 0, 20, -7);
      put_imm(LW, 0, 21, 1);
      put_nops();
      put_imm(SW, 19, 20, 0);
      put_imm(SW, 19, 21, 1);
      put_imm(SW, 19, 1, -7);
      put_imm(LW, 19, 22, 0);
      put_imm(LW, 19, 23, 1);
      put_imm(LW, 19, 24, -7);
      put_nops();
      put_rr(ADD, 22, 23, 25);
      put_imm(HLT, 0, 0, 0);
    end
    3: begin
      put_imm(ADDI, 0, 26, 1);
      put_rr(ADD, 0, 0, 27);
      put_nops();
      put_imm(BEQZ, 26, 0, 3);
      put_imm(ADDI, 0, 28, 11);
      put_imm(BNEQZ, 26, 0, 2);
      // Wrong path behind a taken branch
      put_imm(ADDI, 0, 28, 99);
      put_imm(SW, 0, 26, 5);
      put_imm(ADDI, 0, 29, 22);
      put_imm(BEQZ, 27, 0, 2);
      put_imm(ADDI, 0, 29, 77);
      put_imm(ADDI, 0, 30, 88);
      put_imm(BNEQZ, 27, 0, 1);
      put_imm(ADDI, 0, 31, 33);
      put_imm(HLT, 0, 0, 0);
    end
    4: begin
      // Run twice, registers carry over
      bp   = 1'b1;
      runs = 2;
      data_q.push_back(32'h0000_0100);
      put_imm(ADDI, 12, 12, 5);
      put_imm(LW, 0, 3, 0);
      put_nops();
      put_rr(ADD, 4, 3, 4);
      put_nops();
      put_imm(SW, 0, 4, 7);
      put_imm(HLT, 0, 0, 0);
    end
    default: ;
  endcase
endtask

// ==== sim/tb_mips.sv ====
// Model assumes 256-word memories and programs that keep three instructions between dependencies
`timescale 1ns/1ns
`default_nettype none

module tb_mips;
  import mips_pkg::*;

  localparam int DEPTH = 256;

  logic       clk_1;
  logic       rst;
  logic       prog_valid;
  logic       prog_ready;
  prog_word_t prog_data;
  logic       start;
  logic       rd_valid;
  logic       rd_ready;
  rd_req_t    rd_req;
  logic       rsp_valid;
  logic       rsp_ready;
  word_t      rsp_data;
  logic       running;
  logic       halted;

  // Reference model state
  word_t m_imem [DEPTH];
  word_t m_dmem [DEPTH];
  word_t m_regs [32];

  word_t prog_q [$];
  word_t data_q [$];
  logic  bp;
  int    runs;
  int    seed = 32'h91bb_921e;
  int    errors;
  int    row_errors;
  int    failed_rows;
  int    checks;

  mips_core_top #(.IMEM_DEPTH(DEPTH), .DMEM_DEPTH(DEPTH)) dut_i (.*);

  initial begin
    clk_1 = 1'b0;
    forever #50 clk_1 = ~clk_1;
  end

  task automatic put_rr(input opcode_t op, input int rs, input int rt, input int rd);
    prog_q.push_back({op, rs[4:0], rt[4:0], rd[4:0], 11'd0});
  endtask

  task automatic put_imm(input opcode_t op, input int rs, input int rt, input int imm);
    prog_q.push_back({op, rs[4:0], rt[4:0], imm[15:0]});
  endtask

  // Opcode 7 is unassigned and decodes as a bubble
  task automatic put_nops();
    repeat (3) prog_q.push_back({6'd7, 26'd0});
  endtask

  `include "tb_mips_cases.svh"

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      row_errors++;
    end
  endtask

  // Sequential ISA semantics, a taken branch simply skips ahead
  task automatic run_model();
    word_t   pc;
    word_t   ir;
    word_t   a;
    word_t   b;
    word_t   imm;
    word_t   addr;
    opcode_t op;
    int      steps;
    logic    done;
    pc    = '0;
    steps = 0;
    done  = 1'b0;
    while (!done) begin
      ir   = m_imem[pc[7:0]];
      op   = opcode_t'(ir[31:26]);
      a    = m_regs[ir[25:21]];
      b    = m_regs[ir[20:16]];
      imm  = {{16{ir[15]}}, ir[15:0]};
      addr = a + imm;
      pc   = pc + 32'd1;
      case (op)
        ADD:   m_regs[ir[15:11]] = a + b;
        SUB:   m_regs[ir[15:11]] = a - b;
        AND:   m_regs[ir[15:11]] = a & b;
        OR:    m_regs[ir[15:11]] = a | b;
        SLT:   m_regs[ir[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        MUL:   m_regs[ir[15:11]] = a * b;
        ADDI:  m_regs[ir[20:16]] = a + imm;
        SUBI:  m_regs[ir[20:16]] = a - imm;
        SLTI:  m_regs[ir[20:16]] = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
        LW:    m_regs[ir[20:16]] = m_dmem[addr[7:0]];
        SW:    m_dmem[addr[7:0]] = b;
        BEQZ:  if (a == '0) pc = pc + imm;
        BNEQZ: if (a != '0) pc = pc + imm;
        HLT:   done = 1'b1;
        default: ;
      endcase
      m_regs[0] = '0;
      steps++;
      if (steps > 1000) begin
        $display("reference model ran 1000 instructions without reaching HLT");
        row_errors++;
        done = 1'b1;
      end
    end
  endtask

  task automatic load_word(input mem_sel_t sel, input word_t addr, input word_t data);
    @(posedge clk_1);
    prog_valid <= 1'b1;
    prog_data  <= {sel, addr, data};
    @(negedge clk_1);
    while (!prog_ready) @(negedge clk_1);
    @(posedge clk_1);
    prog_valid <= 1'b0;
  endtask

  task automatic load_row();
    word_t w;
    for (int i = 0; i < prog_q.size(); i++) begin
      load_word(SEL_IMEM, i, prog_q[i]);
      m_imem[i] = prog_q[i];
    end
    for (int i = 0; i < DATA_USED; i++) begin
      w = (i < data_q.size()) ? data_q[i] : (32'hdead_0000 ^ word_t'(i));
      load_word(SEL_DMEM, i, w);
      m_dmem[i] = w;
    end
  endtask

  task automatic read_check(input mem_sel_t sel, input word_t addr, input string name,
                            input word_t exp);
    word_t rnd;
    logic  got;
    int    waits;
    got   = 1'b0;
    waits = 0;
    @(posedge clk_1);
    rd_valid <= 1'b1;
    rd_req   <= {sel, addr};
    @(negedge clk_1);
    while (!rd_ready) @(negedge clk_1);
    @(posedge clk_1);
    rd_valid <= 1'b0;
    while (!got) begin
      rnd = $random(seed);
      rsp_ready <= bp ? rnd[0] : 1'b1;
      @(negedge clk_1);
      if (waits == 0) begin
        check_value("rsp_valid", word_t'(rsp_valid), 32'd1);
      end
      if (rsp_valid && rsp_ready) begin
        check_value($sformatf("%s[%0d]", name, addr), rsp_data, exp);
        got = 1'b1;
      end
      waits++;
      @(posedge clk_1);
    end
    // Exactly one response per request
    @(negedge clk_1);
    check_value("rsp_valid", word_t'(rsp_valid), 32'd0);
  endtask

  task automatic read_back();
    for (int i = 0; i < prog_q.size(); i++) begin
      read_check(SEL_IMEM, i, "imem", m_imem[i]);
    end
    for (int i = 0; i < DATA_USED; i++) begin
      read_check(SEL_DMEM, i, "dmem", m_dmem[i]);
    end
    for (int i = 0; i < 32; i++) begin
      read_check(SEL_REG, i, "reg", m_regs[i]);
    end
  endtask

  task automatic run_core();
    @(posedge clk_1);
    start <= 1'b1;
    @(posedge clk_1);
    start <= 1'b0;
    @(negedge clk_1);
    while (!halted) begin
      check_value("running", word_t'(running), 32'd1);
      check_value("prog_ready", word_t'(prog_ready), 32'd0);
      check_value("rd_ready", word_t'(rd_ready), 32'd0);
      @(negedge clk_1);
    end
    check_value("running", word_t'(running), 32'd0);
  endtask

  initial begin
    repeat (NUM_ROWS * 2000) @(posedge clk_1);
    $display("timeout after %0d cycles with the tests still running", NUM_ROWS * 2000);
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst         <= 1'b0;
    prog_valid  <= 1'b0;
    prog_data   <= '0;
    start       <= 1'b0;
    rd_valid    <= 1'b0;
    rd_req      <= '0;
    rsp_ready   <= 1'b0;
    errors      = 0;
    failed_rows = 0;
    checks      = 0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    repeat (10) @(posedge clk_1);
    rst <= 1'b1;
    for (int row = 0; row < NUM_ROWS; row++) begin
      row_errors = 0;
      build_row(row);
      load_row();
      for (int r = 0; r < runs; r++) begin
        run_core();
        run_model();
      end
      read_back();
      if (row_errors != 0) begin
        failed_rows++;
      end
      errors += row_errors;
      $display("test %0d: %0d words, %0d runs, %0d errors", row, prog_q.size(), runs,
               row_errors);
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors", NUM_ROWS, failed_rows,
             checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+sim
verilog/mips_pkg.sv
verilog/mips_ctrl.sv
verilog/mips_fetch.sv
verilog/mips_decode.sv
verilog/mips_regfile.sv
verilog/mips_execute.sv
verilog/mips_mem_wb.sv
verilog/mips_core_top.sv
sim/tb_mips.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and decide pass or fail from its output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f sim.f --top-module tb_mips -Mdir obj_dir -o tb_mips

output=$(./obj_dir/tb_mips)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
  exit 0
fi
exit 1
